//--- src.f
+incdir+include
hw/split_pkg.sv
hw/axis_if.sv
hw/split_regs.sv
hw/stream_copy.sv
hw/hdr_trunc.sv
hw/stream_pipe.sv
hw/header_split.sv
hw/split_top.sv
bench/tb_split_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the header splitter testbench with Verilator.

cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_split_top -f src.f
build_status=$?
if [ $build_status -ne 0 ]; then
   echo "verilator build failed with status $build_status"
   exit 1
fi

./obj_dir/Vtb_split_top > "$log_file" 2>&1
run_status=$?
cat "$log_file"

if grep -q "TESTBENCH FAILED" "$log_file"; then
   echo "simulation reported a failure"
   exit 1
fi

if [ $run_status -ne 0 ]; then
   echo "simulation exited with status $run_status"
   exit 1
fi

echo "simulation finished without failures"
exit 0

//--- bench/tb_split_top.sv
// directed testbench of the header splitter top level.
// reference model queues, one task per behavior and a watchdog.

`timescale 1ns/1ps

`include "split_defs.svh"

module tb_split_top;

   localparam int NUM_PKTS        = 42;
   localparam int MAX_PKT_WORDS   = 6;
   localparam int WATCHDOG_CYCLES = NUM_PKTS * MAX_PKT_WORDS * 20 + 1000;

   typedef struct packed {
      logic [split_pkg::DATA_WID-1:0]   data;
      logic [split_pkg::DATA_BYTES-1:0] keep;
      logic                             last;
      logic [split_pkg::USER_WID-1:0]   user;
      logic [split_pkg::PID_WID-1:0]    pid;
      logic                             hdr_last;
   } word_t;

   logic                               clk;
   logic                               reset;
   logic                               cfg_wr;
   logic [split_pkg::CFG_ADDR_WID-1:0] cfg_addr;
   logic [15:0]                        cfg_wdata;
   logic                               in_tvalid;
   logic [split_pkg::DATA_WID-1:0]     in_tdata;
   logic [split_pkg::DATA_BYTES-1:0]   in_tkeep;
   logic                               in_tlast;
   logic [split_pkg::USER_WID-1:0]     in_tuser;
   logic                               in_tready;
   logic                               out_tvalid;
   logic [split_pkg::DATA_WID-1:0]     out_tdata;
   logic [split_pkg::DATA_BYTES-1:0]   out_tkeep;
   logic                               out_tlast;
   logic [split_pkg::USER_WID-1:0]     out_tuser;
   logic [split_pkg::PID_WID-1:0]      out_pid;
   logic                               out_hdr_last;
   logic                               out_tready;
   logic                               hdr_tvalid;
   logic [split_pkg::DATA_WID-1:0]     hdr_tdata;
   logic [split_pkg::DATA_BYTES-1:0]   hdr_tkeep;
   logic                               hdr_tlast;
   logic [split_pkg::USER_WID-1:0]     hdr_tuser;
   logic [split_pkg::PID_WID-1:0]      hdr_pid;
   logic                               hdr_tready;

   // ingress words to send and the predicted output words.
   word_t                         in_q[$];
   word_t                         pkt_q[$];
   word_t                         hdr_q[$];
   logic [split_pkg::PID_WID-1:0] next_pid;
   logic [split_pkg::LEN_WID-1:0] cur_hlen;

   split_top u_split_top (
      .clk(clk), .reset(reset),
      .cfg_wr(cfg_wr), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
      .in_tvalid(in_tvalid), .in_tdata(in_tdata), .in_tkeep(in_tkeep),
      .in_tlast(in_tlast), .in_tuser(in_tuser), .in_tready(in_tready),
      .out_tvalid(out_tvalid), .out_tdata(out_tdata), .out_tkeep(out_tkeep),
      .out_tlast(out_tlast), .out_tuser(out_tuser), .out_pid(out_pid),
      .out_hdr_last(out_hdr_last), .out_tready(out_tready),
      .hdr_tvalid(hdr_tvalid), .hdr_tdata(hdr_tdata), .hdr_tkeep(hdr_tkeep),
      .hdr_tlast(hdr_tlast), .hdr_tuser(hdr_tuser), .hdr_pid(hdr_pid),
      .hdr_tready(hdr_tready)
   );

   always #5 clk = ~clk;

   task automatic stop_with_error(input string line);
      $display("%s", line);
      $display("TESTBENCH FAILED");
      $fatal(1, "run stopped at the first failure");
   endtask

   // lower n byte lanes set.
   function automatic logic [split_pkg::DATA_BYTES-1:0] low_bytes(input int n);
      logic [split_pkg::DATA_BYTES-1:0] m;
      for (int i = 0; i < split_pkg::DATA_BYTES; i++) begin
         m[i] = (i < n);
      end
      return m;
   endfunction

   function automatic logic [split_pkg::DATA_WID-1:0] expand_keep(
      input logic [split_pkg::DATA_BYTES-1:0] keep
   );
      logic [split_pkg::DATA_WID-1:0] m;
      for (int i = 0; i < split_pkg::DATA_BYTES; i++) begin
         m[i*8 +: 8] = {8{keep[i]}};
      end
      return m;
   endfunction

   task automatic write_cfg(input logic [1:0] addr, input logic [15:0] data);
      @(negedge clk);
      cfg_wr    = 1'b1;
      cfg_addr  = addr;
      cfg_wdata = data;
      @(negedge clk);
      cfg_wr = 1'b0;
   endtask

   // ------------------------------
   // reference model
   // ------------------------------

   // header is the first min(hdr_length, packet bytes) bytes on the first pid.
   task automatic add_packet(input int nwords);
      word_t                         w;
      int                            i;
      int                            last_bytes;
      int                            pkt_bytes;
      int                            hdr_bytes;
      int                            hdr_words;
      logic [split_pkg::PID_WID-1:0] first_pid;
      last_bytes = 1 + ($urandom % split_pkg::DATA_BYTES);
      pkt_bytes  = (nwords - 1) * split_pkg::DATA_BYTES + last_bytes;
      hdr_bytes  = (int'(cur_hlen) < pkt_bytes) ? int'(cur_hlen) : pkt_bytes;
      hdr_words  = (hdr_bytes + split_pkg::DATA_BYTES - 1) / split_pkg::DATA_BYTES;
      first_pid  = next_pid;
      for (i = 0; i < nwords; i++) begin
         w.data     = {$urandom, $urandom};
         w.keep     = (i == nwords - 1) ? low_bytes(last_bytes) : '1;
         w.last     = (i == nwords - 1);
         w.user     = split_pkg::USER_WID'($urandom);
         w.pid      = next_pid;
         w.hdr_last = (i == hdr_words - 1);
         in_q.push_back(w);
         pkt_q.push_back(w);
         if (i < hdr_words) begin
            w.keep     = w.keep & low_bytes(hdr_bytes - i * split_pkg::DATA_BYTES);
            w.last     = (i == hdr_words - 1);
            w.pid      = first_pid;
            w.hdr_last = 1'b0;
            hdr_q.push_back(w);
         end
         next_pid = next_pid + 1'b1;
      end
   endtask

   // ------------------------------
   // one clock of traffic
   // ------------------------------

   // outputs come from flops and do not follow ready.
   task automatic step_cycle(input bit stall);
      word_t exp;
      logic [split_pkg::DATA_WID-1:0] m;
      @(negedge clk);
      out_tready = stall ? ($urandom % 3 != 0) : 1'b1;
      hdr_tready = stall ? ($urandom % 3 != 0) : 1'b1;
      if (out_tvalid && out_tready) begin
         assert (pkt_q.size() > 0) else begin
            stop_with_error($sformatf("ERR %0t: packet word with none expected", $time));
         end
         exp = pkt_q.pop_front();
         assert (out_tdata == exp.data && out_tkeep == exp.keep && out_tlast == exp.last
                 && out_tuser == exp.user && out_pid == exp.pid
                 && out_hdr_last == exp.hdr_last) else begin
            stop_with_error($sformatf(
               "ERR %0t: packet word %h %h %b %h %0d %b, expected %h %h %b %h %0d %b",
               $time, out_tdata, out_tkeep, out_tlast, out_tuser, out_pid, out_hdr_last,
               exp.data, exp.keep, exp.last, exp.user, exp.pid, exp.hdr_last));
         end
      end
      if (hdr_tvalid && hdr_tready) begin
         assert (hdr_q.size() > 0) else begin
            stop_with_error($sformatf("ERR %0t: header word with none expected", $time));
         end
         exp = hdr_q.pop_front();
         m   = expand_keep(exp.keep);
         assert ((hdr_tdata & m) == (exp.data & m) && hdr_tkeep == exp.keep
                 && hdr_tlast == exp.last && hdr_tuser == exp.user
                 && hdr_pid == exp.pid) else begin
            stop_with_error($sformatf(
               "ERR %0t: header word %h %h %b %h %0d, expected %h %h %b %h %0d",
               $time, hdr_tdata, hdr_tkeep, hdr_tlast, hdr_tuser, hdr_pid,
               exp.data, exp.keep, exp.last, exp.user, exp.pid));
         end
      end
      // hold the word until in_tready takes it.
      if (in_q.size() > 0) begin
         in_tvalid = 1'b1;
         in_tdata  = in_q[0].data;
         in_tkeep  = in_q[0].keep;
         in_tlast  = in_q[0].last;
         in_tuser  = in_q[0].user;
         if (in_tready) begin
            void'(in_q.pop_front());
         end
      end else begin
         in_tvalid = 1'b0;
      end
   endtask

   // idle cycles at the end catch extra words.
   task automatic run_traffic(input bit stall);
      int i;
      while (in_q.size() > 0 || pkt_q.size() > 0 || hdr_q.size() > 0) begin
         step_cycle(stall);
      end
      for (i = 0; i < 8; i++) begin
         step_cycle(stall);
      end
   endtask

   // ------------------------------
   // directed tests
   // ------------------------------

   task automatic check_disabled();
      int i;
      in_tvalid = 1'b1;
      in_tkeep  = '1;
      for (i = 0; i < 10; i++) begin
         @(negedge clk);
         assert (!in_tready && !out_tvalid && !hdr_tvalid) else begin
            stop_with_error($sformatf("ERR %0t: splitter active before enable", $time));
         end
      end
      in_tvalid = 1'b0;
   endtask

   task automatic pass_through();
      int i;
      cur_hlen = `SPLIT_HLEN_RESET;
      write_cfg(`SPLIT_ADDR_CTRL, 16'd1);
      next_pid = '0;
      for (i = 0; i < 6; i++) begin
         add_packet(1 + ($urandom % MAX_PKT_WORDS));
      end
      run_traffic(1'b0);
   endtask

   task automatic header_copy();
      int lens[3];
      int k;
      int j;
      lens = '{5, 16, 20};
      for (k = 0; k < 3; k++) begin
         cur_hlen = split_pkg::LEN_WID'(lens[k]);
         write_cfg(`SPLIT_ADDR_HLEN, cur_hlen);
         for (j = 0; j < 5; j++) begin
            add_packet(1 + j);
         end
         run_traffic(1'b0);
      end
   endtask

   task automatic back_pressure();
      int i;
      cur_hlen = 16'd20;
      write_cfg(`SPLIT_ADDR_HLEN, cur_hlen);
      for (i = 0; i < 12; i++) begin
         add_packet(1 + ($urandom % MAX_PKT_WORDS));
      end
      run_traffic(1'b1);
   endtask

   task automatic re_enable();
      int i;
      write_cfg(`SPLIT_ADDR_CTRL, 16'd0);
      repeat (3) @(negedge clk);
      assert (!in_tready) else begin
         stop_with_error($sformatf("ERR %0t: in_tready high while disabled", $time));
      end
      write_cfg(`SPLIT_ADDR_CTRL, 16'd1);
      next_pid = '0;
      for (i = 0; i < 4; i++) begin
         add_packet(1 + ($urandom % MAX_PKT_WORDS));
      end
      run_traffic(1'b1);
   endtask

   task automatic zero_header();
      int i;
      cur_hlen = '0;
      write_cfg(`SPLIT_ADDR_HLEN, cur_hlen);
      for (i = 0; i < 5; i++) begin
         add_packet(1 + ($urandom % MAX_PKT_WORDS));
      end
      run_traffic(1'b1);
   endtask

   initial begin
      void'($urandom(32'hdc80c012));
      clk        = 1'b0;
      reset      = 1'b1;
      cfg_wr     = 1'b0;
      cfg_addr   = '0;
      cfg_wdata  = '0;
      in_tvalid  = 1'b0;
      in_tdata   = '0;
      in_tkeep   = '0;
      in_tlast   = 1'b0;
      in_tuser   = '0;
      out_tready = 1'b0;
      hdr_tready = 1'b0;
      next_pid   = '0;
      cur_hlen   = `SPLIT_HLEN_RESET;
      repeat (3) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      check_disabled();
      pass_through();
      header_copy();
      back_pressure();
      re_enable();
      zero_header();
      $display("TESTBENCH PASSED");
      $finish;
   end

   // budget of about twenty cycles per word.
   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      stop_with_error("the run timed out because the DUT stopped moving words");
   end

endmodule

//--- hw/split_top.sv
// top level of the header splitter.
// configuration registers and splitter on plain ports.

`timescale 1ns/1ps

module split_top (
   input  logic                                clk,
   input  logic                                reset,
   input  logic                                cfg_wr,
   input  logic [split_pkg::CFG_ADDR_WID-1:0]  cfg_addr,
   input  logic [15:0]                         cfg_wdata,
   input  logic                                in_tvalid,
   input  logic [split_pkg::DATA_WID-1:0]      in_tdata,
   input  logic [split_pkg::DATA_BYTES-1:0]    in_tkeep,
   input  logic                                in_tlast,
   input  logic [split_pkg::USER_WID-1:0]      in_tuser,
   output logic                                in_tready,
   output logic                                out_tvalid,
   output logic [split_pkg::DATA_WID-1:0]      out_tdata,
   output logic [split_pkg::DATA_BYTES-1:0]    out_tkeep,
   output logic                                out_tlast,
   output logic [split_pkg::USER_WID-1:0]      out_tuser,
   output logic [split_pkg::PID_WID-1:0]       out_pid,
   output logic                                out_hdr_last,
   input  logic                                out_tready,
   output logic                                hdr_tvalid,
   output logic [split_pkg::DATA_WID-1:0]      hdr_tdata,
   output logic [split_pkg::DATA_BYTES-1:0]    hdr_tkeep,
   output logic                                hdr_tlast,
   output logic [split_pkg::USER_WID-1:0]      hdr_tuser,
   output logic [split_pkg::PID_WID-1:0]       hdr_pid,
   input  logic                                hdr_tready
);

   logic                          enable;
   logic [split_pkg::LEN_WID-1:0] hdr_length;

   axis_if in_if  (.clk(clk));
   axis_if pkt_if (.clk(clk));
   axis_if hdr_if (.clk(clk));

   // ingress has no pid or header flag yet.
   assign in_if.tvalid   = in_tvalid;
   assign in_if.tdata    = in_tdata;
   assign in_if.tkeep    = in_tkeep;
   assign in_if.tlast    = in_tlast;
   assign in_if.tuser    = in_tuser;
   assign in_if.pid      = '0;
   assign in_if.hdr_last = 1'b0;
   assign in_tready      = in_if.tready;

   assign out_tvalid    = pkt_if.tvalid;
   assign out_tdata     = pkt_if.tdata;
   assign out_tkeep     = pkt_if.tkeep;
   assign out_tlast     = pkt_if.tlast;
   assign out_tuser     = pkt_if.tuser;
   assign out_pid       = pkt_if.pid;
   assign out_hdr_last  = pkt_if.hdr_last;
   assign pkt_if.tready = out_tready;

   assign hdr_tvalid    = hdr_if.tvalid;
   assign hdr_tdata     = hdr_if.tdata;
   assign hdr_tkeep     = hdr_if.tkeep;
   assign hdr_tlast     = hdr_if.tlast;
   assign hdr_tuser     = hdr_if.tuser;
   assign hdr_pid       = hdr_if.pid;
   assign hdr_if.tready = hdr_tready;

   split_regs u_regs (
      .clk        (clk),
      .reset      (reset),
      .cfg_wr     (cfg_wr),
      .cfg_addr   (cfg_addr),
      .cfg_wdata  (cfg_wdata),
      .enable     (enable),
      .hdr_length (hdr_length)
   );

   header_split u_split (
      .clk        (clk),
      .reset      (reset),
      .enable     (enable),
      .hdr_length (hdr_length),
      .ingress    (in_if),
      .pkt_out    (pkt_if),
      .hdr_out    (hdr_if)
   );

endmodule

//--- hw/header_split.sv
// packet header splitter.
// tags each ingress word with the write pointer, forks the stream,
// truncates one branch to the header and registers both outputs.

`timescale 1ns/1ps

module header_split (
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          enable,
   input  logic [split_pkg::LEN_WID-1:0] hdr_length,
   axis_if.rx                            ingress,
   axis_if.tx                            pkt_out,
   axis_if.tx                            hdr_out
);

   logic                          rst_int;
   logic [split_pkg::PID_WID-1:0] wr_ptr;
   logic                          hdr_sop;
   logic [split_pkg::PID_WID-1:0] hdr_pid;

   axis_if to_copy  (.clk(clk));
   axis_if to_trunc (.clk(clk));
   axis_if pkt_p    (.clk(clk));
   axis_if hdr_raw  (.clk(clk));
   axis_if hdr_p    (.clk(clk));

   // held in reset while disabled.
   always_ff @(posedge clk) begin
      rst_int <= reset || !enable;
   end

   // ------------------------------
   // write pointer and tagging
   // ------------------------------

   always_ff @(posedge clk) begin
      if (rst_int) begin
         wr_ptr <= '0;
      end else if (ingress.tvalid && ingress.tready) begin
         wr_ptr <= wr_ptr + 1'b1;
      end
   end

   assign to_copy.tvalid   = ingress.tvalid && !rst_int;
   assign to_copy.tdata    = ingress.tdata;
   assign to_copy.tkeep    = ingress.tkeep;
   assign to_copy.tlast    = ingress.tlast;
   assign to_copy.tuser    = ingress.tuser;
   assign to_copy.pid      = wr_ptr;
   // header copy ends on this word.
   assign to_copy.hdr_last = hdr_raw.tvalid && hdr_raw.tlast;
   assign ingress.tready   = to_copy.tready && !rst_int;

   stream_copy u_copy (
      .src   (to_copy),
      .dst_a (to_trunc),
      .dst_b (pkt_p)
   );

   hdr_trunc u_trunc (
      .clk        (clk),
      .reset      (rst_int),
      .src        (to_trunc),
      .dst        (hdr_raw),
      .hdr_length (hdr_length)
   );

   // ------------------------------
   // header pid
   // ------------------------------

   always_ff @(posedge clk) begin
      if (rst_int) begin
         hdr_sop <= 1'b1;
      end else if (hdr_raw.tvalid && hdr_raw.tready) begin
         hdr_sop <= hdr_raw.tlast;
      end
   end

   // start pointer of the packet, kept for the rest of the header.
   always_ff @(posedge clk) begin
      if (hdr_raw.tvalid && hdr_sop) begin
         hdr_pid <= hdr_raw.pid;
      end
   end

   assign hdr_p.tvalid   = hdr_raw.tvalid;
   assign hdr_p.tdata    = hdr_raw.tdata;
   assign hdr_p.tkeep    = hdr_raw.tkeep;
   assign hdr_p.tlast    = hdr_raw.tlast;
   assign hdr_p.tuser    = hdr_raw.tuser;
   assign hdr_p.pid      = hdr_sop ? hdr_raw.pid : hdr_pid;
   assign hdr_p.hdr_last = 1'b0;
   assign hdr_raw.tready = hdr_p.tready;

   stream_pipe u_pkt_pipe (.clk(clk), .reset(rst_int), .src(pkt_p), .dst(pkt_out));
   stream_pipe u_hdr_pipe (.clk(clk), .reset(rst_int), .src(hdr_p), .dst(hdr_out));

endmodule

//--- hw/stream_pipe.sv
// two-entry register slice for a stream.
// registers payload and ready, one word per cycle under steady ready.

`timescale 1ns/1ps

module stream_pipe (
   input  logic clk,
   input  logic reset,
   axis_if.rx   src,
   axis_if.tx   dst
);

   logic                             out_valid;
   logic                             skid_valid;
   logic [split_pkg::DATA_WID-1:0]   skid_data;
   logic [split_pkg::DATA_BYTES-1:0] skid_keep;
   logic                             skid_last;
   logic [split_pkg::USER_WID-1:0]   skid_user;
   logic [split_pkg::PID_WID-1:0]    skid_pid;
   logic                             skid_hdr_last;
   logic                             out_free;

   // ready comes straight from a flop.
   assign src.tready = !skid_valid;
   assign dst.tvalid = out_valid;
   assign out_free   = !out_valid || dst.tready;

   always_ff @(posedge clk) begin
      if (reset) begin
         out_valid  <= 1'b0;
         skid_valid <= 1'b0;
      end else if (out_free) begin
         out_valid  <= skid_valid || src.tvalid;
         skid_valid <= 1'b0;
      end else if (src.tvalid && src.tready) begin
         // output stalled, park the word in flight.
         skid_valid <= 1'b1;
      end
   end

   // payload.
   always_ff @(posedge clk) begin
      if (out_free) begin
         {dst.tdata, dst.tkeep, dst.tlast, dst.tuser, dst.pid, dst.hdr_last} <= skid_valid ?
            {skid_data, skid_keep, skid_last, skid_user, skid_pid, skid_hdr_last} :
            {src.tdata, src.tkeep, src.tlast, src.tuser, src.pid, src.hdr_last};
      end
      if (!out_free && src.tready) begin
         {skid_data, skid_keep, skid_last, skid_user, skid_pid, skid_hdr_last} <=
            {src.tdata, src.tkeep, src.tlast, src.tuser, src.pid, src.hdr_last};
      end
   end

   // stalled output word holds still.
   a_stable: assert property (
      @(posedge clk) disable iff (reset)
      (dst.tvalid && !dst.tready) |=>
         (dst.tvalid && $stable({dst.tdata, dst.tkeep, dst.tlast, dst.tuser, dst.pid}))
   );

endmodule

//--- hw/hdr_trunc.sv
// header truncation of a packet stream.
// passes the first hdr_length bytes of each packet, ends them with tlast
// and trims tkeep, then swallows the rest of the packet.

`timescale 1ns/1ps

module hdr_trunc (
   input  logic                          clk,
   input  logic                          reset,
   axis_if.rx                            src,
   axis_if.tx                            dst,
   input  logic [split_pkg::LEN_WID-1:0] hdr_length
);

   logic [split_pkg::LEN_WID-1:0]    byte_cnt;
   logic                             in_hdr;
   logic                             pass;
   logic                             hdr_end;
   logic [split_pkg::LEN_WID-1:0]    remaining;
   logic [split_pkg::LEN_WID-1:0]    word_bytes;
   logic [split_pkg::DATA_BYTES-1:0] keep_mask;

   // ------------------------------
   // word decode
   // ------------------------------

   assign pass      = in_hdr && (byte_cnt < hdr_length);
   assign remaining = hdr_length - byte_cnt;

   // valid bytes of this word and the bytes still owed to the header.
   always_comb begin
      word_bytes = '0;
      for (int i = 0; i < split_pkg::DATA_BYTES; i++) begin
         if (src.tkeep[i]) begin
            word_bytes = word_bytes + split_pkg::LEN_WID'(1);
         end
         keep_mask[i] = remaining > split_pkg::LEN_WID'(i);
      end
   end

   // header ends inside or at the end of this word.
   assign hdr_end = remaining <= word_bytes;

   assign dst.tvalid   = src.tvalid && pass;
   assign dst.tdata    = src.tdata;
   assign dst.tkeep    = src.tkeep & keep_mask;
   assign dst.tlast    = src.tlast || hdr_end;
   assign dst.tuser    = src.tuser;
   assign dst.pid      = src.pid;
   assign dst.hdr_last = src.hdr_last;

   // dropped words are always accepted.
   assign src.tready = pass ? dst.tready : 1'b1;

   // ------------------------------
   // per-packet state
   // ------------------------------

   always_ff @(posedge clk) begin
      if (reset) begin
         byte_cnt <= '0;
         in_hdr   <= 1'b1;
      end else if (src.tvalid && src.tready) begin
         if (src.tlast) begin
            byte_cnt <= '0;
            in_hdr   <= 1'b1;
         end else if (!pass || hdr_end) begin
            in_hdr <= 1'b0;
         end else begin
            byte_cnt <= byte_cnt + word_bytes;
         end
      end
   end

   // forwarded words always hold at least one byte.
   a_keep_nonzero: assert property (
      @(posedge clk) disable iff (reset)
      dst.tvalid |-> (dst.tkeep != '0)
   );

endmodule

//--- hw/stream_copy.sv
// lock-step fork of one stream into two outputs.
// combinational logic that hands each word to both outputs once.

`timescale 1ns/1ps

module stream_copy (
   axis_if.rx src,
   axis_if.tx dst_a,
   axis_if.tx dst_b
);

   // source moves only when both sides can take the word.
   assign src.tready = dst_a.tready && dst_b.tready;

   // each side is offered the word only if the other can accept it.
   assign dst_a.tvalid = src.tvalid && dst_b.tready;
   assign dst_b.tvalid = src.tvalid && dst_a.tready;

   assign dst_a.tdata    = src.tdata;
   assign dst_a.tkeep    = src.tkeep;
   assign dst_a.tlast    = src.tlast;
   assign dst_a.tuser    = src.tuser;
   assign dst_a.pid      = src.pid;
   assign dst_a.hdr_last = src.hdr_last;

   assign dst_b.tdata    = src.tdata;
   assign dst_b.tkeep    = src.tkeep;
   assign dst_b.tlast    = src.tlast;
   assign dst_b.tuser    = src.tuser;
   assign dst_b.pid      = src.pid;
   assign dst_b.hdr_last = src.hdr_last;

   // a stalled source word holds still until both sides take it.
   a_src_hold: assert property (
      @(posedge src.clk)
      (src.tvalid && !src.tready)
         |=> (!src.tvalid || $stable({src.tdata, src.tkeep, src.tlast, src.tuser, src.pid}))
   );

endmodule

//--- hw/split_regs.sv
// configuration registers of the header splitter.
// enable bit and header length, written by a one-cycle strobe.

`timescale 1ns/1ps

`include "split_defs.svh"

module split_regs (
   input  logic                                clk,
   input  logic                                reset,
   input  logic                                cfg_wr,
   input  logic [split_pkg::CFG_ADDR_WID-1:0]  cfg_addr,
   input  logic [15:0]                         cfg_wdata,
   output logic                                enable,
   output logic [split_pkg::LEN_WID-1:0]       hdr_length
);

   // ------------------------------
   // write decode
   // ------------------------------

   // writes land on the next edge.
   // unknown addresses are ignored.
   always_ff @(posedge clk) begin
      if (reset) begin
         enable     <= 1'b0;
         hdr_length <= `SPLIT_HLEN_RESET;
      end else if (cfg_wr) begin
         case (cfg_addr)
            `SPLIT_ADDR_CTRL: begin
               enable <= cfg_wdata[0];
            end
            `SPLIT_ADDR_HLEN: begin
               hdr_length <= cfg_wdata;
            end
            default: begin
            end
         endcase
      end
   end

endmodule

//--- hw/axis_if.sv
// stream interface with valid/ready handshake.
// tx and rx modports, pid and header end flag as own signals.

`timescale 1ns/1ps

interface axis_if (
   input logic clk
);

   logic                            tvalid;
   logic                            tready;
   logic [split_pkg::DATA_WID-1:0]   tdata;
   logic [split_pkg::DATA_BYTES-1:0] tkeep;
   logic                            tlast;
   logic [split_pkg::USER_WID-1:0]   tuser;
   // packet id, a write pointer value.
   logic [split_pkg::PID_WID-1:0]    pid;
   // last word of the header copy.
   logic                            hdr_last;

   // sender side.
   modport tx (
      input  clk,
      input  tready,
      output tvalid, tdata, tkeep, tlast, tuser, pid, hdr_last
   );

   // receiver side.
   modport rx (
      input  clk,
      output tready,
      input  tvalid, tdata, tkeep, tlast, tuser, pid, hdr_last
   );

endinterface

//--- hw/split_pkg.sv
// widths shared by the header splitter.
// stream word, tuser, pid and configuration sizes.

package split_pkg;

   // bytes per stream word.
   localparam int DATA_BYTES = 8;

   // data width in bits.
   localparam int DATA_WID = DATA_BYTES * 8;

   // opaque tuser carried through unchanged.
   localparam int USER_WID = 4;

   // write pointer and pid width.
   localparam int PID_WID = 16;

   // header length width, in bytes.
   localparam int LEN_WID = 16;

   // configuration address width.
   localparam int CFG_ADDR_WID = 2;

endpackage

//--- include/split_defs.svh
// register map of the splitter configuration port.
// addresses and the reset value of the header length.

`ifndef SPLIT_DEFS_SVH
`define SPLIT_DEFS_SVH

// control register, bit 0 is enable.
`define SPLIT_ADDR_CTRL 2'd0

// header length in bytes.
`define SPLIT_ADDR_HLEN 2'd1

// header length after reset.
`define SPLIT_HLEN_RESET 16'd16

`endif
